/* source/axi_lite_pkg.sv */
// ====================
// axi-lite interconnect package
// widths, channel structs, response codes and router states
// ====================
package axi_lite_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // port index, wide enough for up to 8 subordinates
    localparam int sel_w = 3;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;
    typedef logic [sel_w-1:0]  sel_t;

    // standard axi response encoding
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // address channel, shared by aw and ar
    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } aw_chan_t;

    typedef aw_chan_t ar_chan_t;

    // write data channel
    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    // write response channel
    typedef struct packed {
        axi_resp_e resp;
    } b_chan_t;

    // read data channel
    typedef struct packed {
        data_t     data;
        axi_resp_e resp;
    } r_chan_t;

    // write router: address, then data, then response
    typedef enum logic [1:0] {
        wr_idle = 2'b00,
        wr_data = 2'b01,
        wr_resp = 2'b10
    } wr_state_e;

    // read router: address, then response
    typedef enum logic {
        rd_idle = 1'b0,
        rd_resp = 1'b1
    } rd_state_e;

endpackage

/* source/axi_lite_write_router.sv */
// ====================
// axi-lite write router
// steers aw and w to one port and returns its b
// ====================
`timescale 1ns/1ns

module axi_lite_write_router #(
    parameter int n_ports = 6
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  axi_lite_pkg::sel_t                   wr_sel,

    // manager side
    input  axi_lite_pkg::aw_chan_t               m_aw,
    input  logic                                 m_aw_valid,
    output logic                                 m_aw_ready,
    input  axi_lite_pkg::w_chan_t                m_w,
    input  logic                                 m_w_valid,
    output logic                                 m_w_ready,
    output axi_lite_pkg::b_chan_t                m_b,
    output logic                                 m_b_valid,
    input  logic                                 m_b_ready,

    // subordinate side
    output axi_lite_pkg::aw_chan_t [n_ports-1:0] s_aw,
    output logic [n_ports-1:0]                   s_aw_valid,
    input  logic [n_ports-1:0]                   s_aw_ready,
    output axi_lite_pkg::w_chan_t [n_ports-1:0]  s_w,
    output logic [n_ports-1:0]                   s_w_valid,
    input  logic [n_ports-1:0]                   s_w_ready,
    input  axi_lite_pkg::b_chan_t [n_ports-1:0]  s_b,
    input  logic [n_ports-1:0]                   s_b_valid,
    output logic [n_ports-1:0]                   s_b_ready
);
    import axi_lite_pkg::*;

    wr_state_e state_q;
    wr_state_e state_d;
    sel_t      port_q;
    logic      dec_err_q;
    logic      sel_hit;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;

    // select names an existing port
    assign sel_hit = int'(wr_sel) < n_ports;

    assign aw_fire = m_aw_valid & m_aw_ready;
    assign w_fire  = m_w_valid & m_w_ready;
    assign b_fire  = m_b_valid & m_b_ready;

    // payload goes to every port, only valid is steered
    always_comb begin
        for (int i = 0; i < n_ports; i++) begin
            s_aw[i] = m_aw;
            s_w[i]  = m_w;
        end
    end

    // aw follows the live select while idle
    always_comb begin
        s_aw_valid = '0;
        m_aw_ready = 1'b0;
        if (state_q == wr_idle && m_aw_valid) begin
            for (int i = 0; i < n_ports; i++) begin
                if (int'(wr_sel) == i) begin
                    s_aw_valid[i] = 1'b1;
                    m_aw_ready    = s_aw_ready[i];
                end
            end
            // no such port, accept here
            if (!sel_hit) begin
                m_aw_ready = 1'b1;
            end
        end
    end

    // w goes to the port latched at the aw transfer
    always_comb begin
        s_w_valid = '0;
        m_w_ready = 1'b0;
        if (state_q == wr_data && m_w_valid) begin
            if (dec_err_q) begin
                m_w_ready = 1'b1;
            end else begin
                for (int i = 0; i < n_ports; i++) begin
                    if (int'(port_q) == i) begin
                        s_w_valid[i] = 1'b1;
                        m_w_ready    = s_w_ready[i];
                    end
                end
            end
        end
    end

    // b comes back from the same port, or locally on a decode error
    always_comb begin
        s_b_ready = '0;
        m_b_valid = 1'b0;
        m_b.resp  = resp_okay;
        if (state_q == wr_resp) begin
            if (dec_err_q) begin
                m_b_valid = 1'b1;
                m_b.resp  = resp_decerr;
            end else begin
                for (int i = 0; i < n_ports; i++) begin
                    if (int'(port_q) == i) begin
                        m_b          = s_b[i];
                        m_b_valid    = s_b_valid[i];
                        s_b_ready[i] = m_b_ready;
                    end
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            wr_idle: if (aw_fire) state_d = wr_data;
            wr_data: if (w_fire) state_d = wr_resp;
            wr_resp: if (b_fire) state_d = wr_idle;
            default: state_d = wr_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= wr_idle;
            port_q    <= '0;
            dec_err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (aw_fire) begin
                port_q    <= wr_sel;
                dec_err_q <= !sel_hit;
            end
        end
    end

    // never more than one subordinate addressed
    a_aw_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(s_aw_valid));
    a_w_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(s_w_valid));
    a_b_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(s_b_ready));

    a_b_in_resp: assert property (@(posedge clk) disable iff (!arst_n)
        m_b_valid |-> state_q == wr_resp);

    // target stays put for w and b
    a_port_hold: assert property (@(posedge clk) disable iff (!arst_n)
        state_q != wr_idle |=> $stable(port_q) && $stable(dec_err_q));

endmodule

/* source/axi_lite_read_router.sv */
// ====================
// axi-lite read router
// steers ar to one port and returns its r
// ====================
`timescale 1ns/1ns

module axi_lite_read_router #(
    parameter int n_ports = 6
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  axi_lite_pkg::sel_t                   rd_sel,

    // manager side
    input  axi_lite_pkg::ar_chan_t               m_ar,
    input  logic                                 m_ar_valid,
    output logic                                 m_ar_ready,
    output axi_lite_pkg::r_chan_t                m_r,
    output logic                                 m_r_valid,
    input  logic                                 m_r_ready,

    // subordinate side
    output axi_lite_pkg::ar_chan_t [n_ports-1:0] s_ar,
    output logic [n_ports-1:0]                   s_ar_valid,
    input  logic [n_ports-1:0]                   s_ar_ready,
    input  axi_lite_pkg::r_chan_t [n_ports-1:0]  s_r,
    input  logic [n_ports-1:0]                   s_r_valid,
    output logic [n_ports-1:0]                   s_r_ready
);
    import axi_lite_pkg::*;

    rd_state_e state_q;
    rd_state_e state_d;
    sel_t      port_q;
    logic      dec_err_q;
    logic      sel_hit;
    logic      ar_fire;
    logic      r_fire;

    assign sel_hit = int'(rd_sel) < n_ports;
    assign ar_fire = m_ar_valid & m_ar_ready;
    assign r_fire  = m_r_valid & m_r_ready;

    // address broadcast
    always_comb begin
        for (int i = 0; i < n_ports; i++) begin
            s_ar[i] = m_ar;
        end
    end

    always_comb begin
        s_ar_valid = '0;
        m_ar_ready = 1'b0;
        if (state_q == rd_idle && m_ar_valid) begin
            for (int i = 0; i < n_ports; i++) begin
                if (int'(rd_sel) == i) begin
                    s_ar_valid[i] = 1'b1;
                    m_ar_ready    = s_ar_ready[i];
                end
            end
            // out of range, taken here and never forwarded
            if (!sel_hit) begin
                m_ar_ready = 1'b1;
            end
        end
    end

    // r from the latched port, zero data with decerr otherwise
    always_comb begin
        s_r_ready = '0;
        m_r_valid = 1'b0;
        m_r.data  = '0;
        m_r.resp  = resp_okay;
        if (state_q == rd_resp) begin
            if (dec_err_q) begin
                m_r_valid = 1'b1;
                m_r.resp  = resp_decerr;
            end else begin
                for (int i = 0; i < n_ports; i++) begin
                    if (int'(port_q) == i) begin
                        m_r          = s_r[i];
                        m_r_valid    = s_r_valid[i];
                        s_r_ready[i] = m_r_ready;
                    end
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            rd_idle: if (ar_fire) state_d = rd_resp;
            rd_resp: if (r_fire) state_d = rd_idle;
            default: state_d = rd_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= rd_idle;
            port_q    <= '0;
            dec_err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ar_fire) begin
                port_q    <= rd_sel;
                dec_err_q <= !sel_hit;
            end
        end
    end

    a_ar_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(s_ar_valid));

    a_r_in_resp: assert property (@(posedge clk) disable iff (!arst_n)
        m_r_valid |-> state_q == rd_resp);

endmodule

/* source/axi_lite_interconnect.sv */
// ====================
// axi-lite interconnect
// one manager to n_ports subordinates, write and read in parallel
// ====================
`timescale 1ns/1ns

module axi_lite_interconnect #(
    parameter int n_ports = 6
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  axi_lite_pkg::sel_t                   wr_sel,
    input  axi_lite_pkg::sel_t                   rd_sel,

    // manager write
    input  axi_lite_pkg::aw_chan_t               m_aw,
    input  logic                                 m_aw_valid,
    output logic                                 m_aw_ready,
    input  axi_lite_pkg::w_chan_t                m_w,
    input  logic                                 m_w_valid,
    output logic                                 m_w_ready,
    output axi_lite_pkg::b_chan_t                m_b,
    output logic                                 m_b_valid,
    input  logic                                 m_b_ready,

    // manager read
    input  axi_lite_pkg::ar_chan_t               m_ar,
    input  logic                                 m_ar_valid,
    output logic                                 m_ar_ready,
    output axi_lite_pkg::r_chan_t                m_r,
    output logic                                 m_r_valid,
    input  logic                                 m_r_ready,

    // subordinate write
    output axi_lite_pkg::aw_chan_t [n_ports-1:0] s_aw,
    output logic [n_ports-1:0]                   s_aw_valid,
    input  logic [n_ports-1:0]                   s_aw_ready,
    output axi_lite_pkg::w_chan_t [n_ports-1:0]  s_w,
    output logic [n_ports-1:0]                   s_w_valid,
    input  logic [n_ports-1:0]                   s_w_ready,
    input  axi_lite_pkg::b_chan_t [n_ports-1:0]  s_b,
    input  logic [n_ports-1:0]                   s_b_valid,
    output logic [n_ports-1:0]                   s_b_ready,

    // subordinate read
    output axi_lite_pkg::ar_chan_t [n_ports-1:0] s_ar,
    output logic [n_ports-1:0]                   s_ar_valid,
    input  logic [n_ports-1:0]                   s_ar_ready,
    input  axi_lite_pkg::r_chan_t [n_ports-1:0]  s_r,
    input  logic [n_ports-1:0]                   s_r_valid,
    output logic [n_ports-1:0]                   s_r_ready
);

    // write path, aw/w/b
    axi_lite_write_router #(
        .n_ports (n_ports)
    ) u_write_router (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_sel     (wr_sel),
        .m_aw       (m_aw),
        .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .m_w_ready  (m_w_ready),
        .m_b        (m_b),
        .m_b_valid  (m_b_valid),
        .m_b_ready  (m_b_ready),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .s_b        (s_b),
        .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready)
    );

    // read path, independent of the write path
    axi_lite_read_router #(
        .n_ports (n_ports)
    ) u_read_router (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_sel     (rd_sel),
        .m_ar       (m_ar),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_r        (m_r),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready)
    );

endmodule

/* tests/axi_lite_subordinate_model.sv */
// ====================
// axi-lite subordinate model
// 16-word memory with random handshake delays
// ====================
`timescale 1ns/1ns

module axi_lite_subordinate_model #(
    parameter int port_id = 0
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  axi_lite_pkg::aw_chan_t aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_lite_pkg::w_chan_t  w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi_lite_pkg::b_chan_t  b,
    output logic                   b_valid,
    input  logic                   b_ready,
    input  axi_lite_pkg::ar_chan_t ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_lite_pkg::r_chan_t  r,
    output logic                   r_valid,
    input  logic                   r_ready
);
    import axi_lite_pkg::*;

    data_t mem [16];

    // 0 to 3 idle cycles, then lands 2 ns after a rising edge
    task automatic pause_random();
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        #2;
    endtask

    // write side, aw then w then b
    initial begin
        addr_t     wr_addr;
        axi_resp_e wr_resp;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h1000_0000 * (port_id + 1) + i * 32'h0001_0101;
        end
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b.resp   = resp_okay;
        wait (arst_n);
        forever begin
            do @(negedge clk); while (!aw_valid);
            pause_random();
            aw_ready = 1'b1;
            @(negedge clk);
            wr_addr = aw.addr;
            @(posedge clk);
            #2;
            aw_ready = 1'b0;
            do @(negedge clk); while (!w_valid);
            pause_random();
            w_ready = 1'b1;
            @(negedge clk);
            wr_resp = (wr_addr[addr_w-1:2] < 16) ? resp_okay : resp_slverr;
            // words past the end are dropped
            if (wr_resp == resp_okay) begin
                for (int k = 0; k < strb_w; k++) begin
                    if (w.strb[k]) begin
                        mem[wr_addr[5:2]][8*k +: 8] = w.data[8*k +: 8];
                    end
                end
            end
            @(posedge clk);
            #2;
            w_ready = 1'b0;
            pause_random();
            b.resp  = wr_resp;
            b_valid = 1'b1;
            do @(negedge clk); while (!b_ready);
            @(posedge clk);
            #2;
            b_valid = 1'b0;
        end
    end

    // read side, ar then r
    initial begin
        addr_t rd_addr;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        wait (arst_n);
        forever begin
            do @(negedge clk); while (!ar_valid);
            pause_random();
            ar_ready = 1'b1;
            @(negedge clk);
            rd_addr = ar.addr;
            @(posedge clk);
            #2;
            ar_ready = 1'b0;
            pause_random();
            if (rd_addr[addr_w-1:2] < 16) begin
                r.data = mem[rd_addr[5:2]];
                r.resp = resp_okay;
            end else begin
                r.data = '0;
                r.resp = resp_slverr;
            end
            r_valid = 1'b1;
            do @(negedge clk); while (!r_ready);
            @(posedge clk);
            #2;
            r_valid = 1'b0;
        end
    end

endmodule

/* tests/tb_axi_lite_interconnect.sv */
// ====================
// testbench for the axi-lite interconnect
// table-driven writes and reads against a reference memory
// ====================
`timescale 1ns/1ns

module tb_axi_lite_interconnect;
    import axi_lite_pkg::*;

    localparam int n_ports   = 6;
    localparam int period    = 40;
    localparam int n_entries = 15;

    // protection bits carried with each address
    localparam logic [2:0] wr_prot = 3'b010;
    localparam logic [2:0] rd_prot = 3'b101;

    typedef enum logic {op_write, op_read} op_kind_e;

    typedef struct {
        op_kind_e kind;
        sel_t     sel;
        addr_t    addr;
        data_t    data;
        strb_t    strb;
        int       rdy_delay;
    } stim_t;

    // kind, select, address, data, strobe, manager ready delay
    stim_t stim [n_entries] = '{
        '{op_write, 3'd0, 32'h00, 32'h1111_2222, 4'hf, 0},
        '{op_read,  3'd0, 32'h00, 32'h0,         4'h0, 0},
        '{op_write, 3'd1, 32'h00, 32'haaaa_5555, 4'hf, 2},
        '{op_read,  3'd0, 32'h00, 32'h0,         4'h0, 1},
        '{op_read,  3'd1, 32'h00, 32'h0,         4'h0, 3},
        '{op_write, 3'd0, 32'h00, 32'hffee_ddcc, 4'h5, 0},
        '{op_read,  3'd0, 32'h00, 32'h0,         4'h0, 2},
        '{op_write, 3'd6, 32'h04, 32'hdead_beef, 4'hf, 1},
        '{op_read,  3'd7, 32'h04, 32'h0,         4'h0, 0},
        '{op_read,  3'd2, 32'h40, 32'h0,         4'h0, 2},
        '{op_write, 3'd3, 32'h80, 32'h1234_5678, 4'hf, 3},
        '{op_read,  3'd5, 32'h3c, 32'h0,         4'h0, 0},
        '{op_write, 3'd5, 32'h3c, 32'h0bad_f00d, 4'hf, 3},
        '{op_read,  3'd5, 32'h3c, 32'h0,         4'h0, 2},
        '{op_read,  3'd4, 32'h08, 32'h0,         4'h0, 1}
    };

    logic                   clk;
    logic                   arst_n;
    sel_t                   wr_sel;
    sel_t                   rd_sel;
    aw_chan_t               m_aw;
    logic                   m_aw_valid;
    logic                   m_aw_ready;
    w_chan_t                m_w;
    logic                   m_w_valid;
    logic                   m_w_ready;
    b_chan_t                m_b;
    logic                   m_b_valid;
    logic                   m_b_ready;
    ar_chan_t               m_ar;
    logic                   m_ar_valid;
    logic                   m_ar_ready;
    r_chan_t                m_r;
    logic                   m_r_valid;
    logic                   m_r_ready;
    aw_chan_t [n_ports-1:0] s_aw;
    logic [n_ports-1:0]     s_aw_valid;
    wire [n_ports-1:0]      s_aw_ready;
    w_chan_t [n_ports-1:0]  s_w;
    logic [n_ports-1:0]     s_w_valid;
    wire [n_ports-1:0]      s_w_ready;
    wire b_chan_t [n_ports-1:0] s_b;
    wire [n_ports-1:0]      s_b_valid;
    logic [n_ports-1:0]     s_b_ready;
    ar_chan_t [n_ports-1:0] s_ar;
    logic [n_ports-1:0]     s_ar_valid;
    wire [n_ports-1:0]      s_ar_ready;
    wire r_chan_t [n_ports-1:0] s_r;
    wire [n_ports-1:0]      s_r_valid;
    logic [n_ports-1:0]     s_r_ready;

    data_t ref_mem [n_ports][16];
    int    n_checks;
    int    n_errors;
    int    b_count;
    int    r_count;
    int    cur;
    logic  sub_valid_seen;

    axi_lite_interconnect #(
        .n_ports (n_ports)
    ) i_dut (.*);

    for (genvar p = 0; p < n_ports; p++) begin : g_sub
        axi_lite_subordinate_model #(
            .port_id (p)
        ) u_sub (
            .clk      (clk),
            .arst_n   (arst_n),
            .aw       (s_aw[p]),
            .aw_valid (s_aw_valid[p]),
            .aw_ready (s_aw_ready[p]),
            .w        (s_w[p]),
            .w_valid  (s_w_valid[p]),
            .w_ready  (s_w_ready[p]),
            .b        (s_b[p]),
            .b_valid  (s_b_valid[p]),
            .b_ready  (s_b_ready[p]),
            .ar       (s_ar[p]),
            .ar_valid (s_ar_valid[p]),
            .ar_ready (s_ar_ready[p]),
            .r        (s_r[p]),
            .r_valid  (s_r_valid[p]),
            .r_ready  (s_r_ready[p])
        );
    end

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // watchdog, 20 clock periods per table entry
    initial begin
        #(n_entries * 20 * period);
        $display("timeout: run did not finish within %0d clock periods", n_entries * 20);
        $display(">>> FAIL");
        $finish;
    end

    // response transfers and any subordinate valid
    always @(negedge clk) begin
        if (m_b_valid && m_b_ready) b_count++;
        if (m_r_valid && m_r_ready) r_count++;
        if (|{s_aw_valid, s_w_valid, s_ar_valid}) sub_valid_seen = 1'b1;
    end

    // power-on contents of each model
    function automatic data_t fill_word(int port, int idx);
        return 32'h1000_0000 * (port + 1) + idx * 32'h0001_0101;
    endfunction

    task automatic report_error(input string msg);
        n_errors++;
        $display("error at %0t ns: entry %0d %s", $time, cur, msg);
    endtask

    task automatic check_resp(input axi_resp_e got, input axi_resp_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: entry %0d resp %s, expected %s",
                     $time, cur, got.name(), exp.name());
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: entry %0d data 0x%08h, expected 0x%08h",
                     $time, cur, got, exp);
        end
    endtask

    task automatic check_addr(input aw_chan_t got, input aw_chan_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: entry %0d address channel 0x%h, expected 0x%h",
                     $time, cur, got, exp);
        end
    endtask

    task automatic do_write(input stim_t s, output axi_resp_e resp);
        aw_chan_t exp_aw;
        exp_aw.addr = s.addr;
        exp_aw.prot = wr_prot;
        @(posedge clk);
        #2;
        sub_valid_seen = 1'b0;
        wr_sel         = s.sel;
        m_aw.addr      = s.addr;
        m_aw.prot      = wr_prot;
        m_aw_valid     = 1'b1;
        m_b_ready      = (s.rdy_delay == 0);
        do @(negedge clk); while (!m_aw_ready);
        // address reaches every port, not only the target
        for (int p = 0; p < n_ports; p++) begin
            check_addr(s_aw[p], exp_aw);
        end
        @(posedge clk);
        #2;
        m_aw_valid = 1'b0;
        m_w.data   = s.data;
        m_w.strb   = s.strb;
        m_w_valid  = 1'b1;
        do @(negedge clk); while (!m_w_ready);
        @(posedge clk);
        #2;
        m_w_valid = 1'b0;
        do @(negedge clk); while (!m_b_valid);
        // hold b back for a few cycles
        if (!m_b_ready) begin
            repeat (s.rdy_delay) @(posedge clk);
            #2;
            m_b_ready = 1'b1;
            @(negedge clk);
            if (!m_b_valid) report_error("write response dropped before ready rose");
        end
        resp = m_b.resp;
        @(posedge clk);
        #2;
        m_b_ready = 1'b0;
        @(negedge clk);
        if (m_b_valid) report_error("write response still valid after its transfer");
    endtask

    task automatic do_read(input stim_t s, output axi_resp_e resp, output data_t data);
        ar_chan_t exp_ar;
        exp_ar.addr = s.addr;
        exp_ar.prot = rd_prot;
        @(posedge clk);
        #2;
        sub_valid_seen = 1'b0;
        rd_sel         = s.sel;
        m_ar.addr      = s.addr;
        m_ar.prot      = rd_prot;
        m_ar_valid     = 1'b1;
        m_r_ready      = (s.rdy_delay == 0);
        do @(negedge clk); while (!m_ar_ready);
        for (int p = 0; p < n_ports; p++) begin
            check_addr(s_ar[p], exp_ar);
        end
        @(posedge clk);
        #2;
        m_ar_valid = 1'b0;
        do @(negedge clk); while (!m_r_valid);
        if (!m_r_ready) begin
            repeat (s.rdy_delay) @(posedge clk);
            #2;
            m_r_ready = 1'b1;
            @(negedge clk);
            if (!m_r_valid) report_error("read response dropped before ready rose");
        end
        resp = m_r.resp;
        data = m_r.data;
        @(posedge clk);
        #2;
        m_r_ready = 1'b0;
        @(negedge clk);
        if (m_r_valid) report_error("read response still valid after its transfer");
    endtask

    initial begin
        axi_resp_e got_resp;
        axi_resp_e exp_resp;
        data_t     got_data;
        data_t     exp_data;
        int        word;
        int        n_writes;
        int        n_reads;
        int        errs_before;
        void'($urandom(51));
        arst_n         = 1'b0;
        wr_sel         = '0;
        rd_sel         = '0;
        m_aw           = '0;
        m_aw_valid     = 1'b0;
        m_w            = '0;
        m_w_valid      = 1'b0;
        m_b_ready      = 1'b0;
        m_ar           = '0;
        m_ar_valid     = 1'b0;
        m_r_ready      = 1'b0;
        n_checks       = 0;
        n_errors       = 0;
        b_count        = 0;
        r_count        = 0;
        n_writes       = 0;
        n_reads        = 0;
        cur            = -1;
        sub_valid_seen = 1'b0;
        for (int p = 0; p < n_ports; p++) begin
            for (int i = 0; i < 16; i++) begin
                ref_mem[p][i] = fill_word(p, i);
            end
        end
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        if (|{m_aw_ready, m_w_ready, m_b_valid, m_ar_ready, m_r_valid}) begin
            report_error("manager side handshake high after reset");
        end
        if (|{s_aw_valid, s_w_valid, s_ar_valid, s_b_valid, s_r_valid}) begin
            report_error("subordinate side valid high after reset");
        end

        for (int e = 0; e < n_entries; e++) begin
            cur         = e;
            errs_before = n_errors;
            word        = int'(stim[e].addr[addr_w-1:2]);
            exp_data    = '0;
            if (stim[e].sel >= n_ports) begin
                exp_resp = resp_decerr;
            end else if (word > 15) begin
                exp_resp = resp_slverr;
            end else begin
                exp_resp = resp_okay;
            end
            if (stim[e].kind == op_write) begin
                // only enabled bytes land in the word
                if (exp_resp == resp_okay) begin
                    for (int k = 0; k < strb_w; k++) begin
                        if (stim[e].strb[k]) begin
                            ref_mem[stim[e].sel][word][8*k +: 8] = stim[e].data[8*k +: 8];
                        end
                    end
                end
                do_write(stim[e], got_resp);
                n_writes++;
                check_resp(got_resp, exp_resp);
            end else begin
                if (exp_resp == resp_okay) exp_data = ref_mem[stim[e].sel][word];
                do_read(stim[e], got_resp, got_data);
                n_reads++;
                check_resp(got_resp, exp_resp);
                check_data(got_data, exp_data);
            end
            if (b_count != n_writes || r_count != n_reads) begin
                report_error("number of responses differs from requests issued");
            end
            if (exp_resp == resp_decerr && sub_valid_seen) begin
                report_error("decode error request reached a subordinate");
            end
            $display("entry %0d %s sel %0d addr 0x%08h: %s", e, stim[e].kind.name(),
                     stim[e].sel, stim[e].addr, (n_errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d entries, %0d checks, %0d errors", n_entries, n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
source/axi_lite_pkg.sv
source/axi_lite_write_router.sv
source/axi_lite_read_router.sv
source/axi_lite_interconnect.sv
tests/axi_lite_subordinate_model.sv
tests/tb_axi_lite_interconnect.sv
